/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    typedef logic [31:0] instr_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

    // Integer groups, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // RV64 shift immediates keep shamt[5] in bit 25
    localparam logic [5:0] F6_BASE = 6'b000000;
    localparam logic [5:0] F6_ALT  = 6'b010000;

    typedef enum logic [5:0] {
        OP_ILLEGAL = 6'd0,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } op_t;

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LT,
        ALU_LTU,
        ALU_SL,
        ALU_SRU,
        ALU_SR,
        ALU_SRUW,   // Word logical right shift
        ALU_SRW,    // Word arithmetic right shift
        ALU_DIRECT  // Pass operand through
    } alu_func_t;

    // All fields zero means illegal
    typedef struct packed {
        op_t       op;
        logic      regwrite;
        alu_func_t alufunc;
        logic      mem_read;
        logic      mem_write;
    } control_t;

endpackage

`default_nettype wire

/* src/pipe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic full;
    T     data_q;
    logic take_in;

    // Empty, or the held item leaves this cycle
    assign in_ready  = !full || out_ready;
    assign take_in   = in_valid && in_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (take_in) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;   // Drained with nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (take_in) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* src/alu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_decode (
    input  logic [6:0]           opcode,
    input  logic [2:0]           funct3,
    input  logic [6:0]           funct7,
    input  logic [5:0]           funct6,
    output decode_pkg::control_t ctl,
    output logic                 hit
);
    import decode_pkg::*;

    function automatic control_t int_ctl(input op_t op_sel, input alu_func_t func_sel);
        return '{op: op_sel, regwrite: 1'b1, alufunc: func_sel,
                 mem_read: 1'b0, mem_write: 1'b0};
    endfunction

    assign hit = opcode inside {OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32};

    always_comb begin
        ctl = '0;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:  ctl = int_ctl(OP_ADD, ALU_ADD);
                    {F7_ALT, F3_ADD}:   ctl = int_ctl(OP_SUB, ALU_SUB);
                    {F7_BASE, F3_SLL}:  ctl = int_ctl(OP_SLL, ALU_SL);
                    {F7_BASE, F3_SLT}:  ctl = int_ctl(OP_SLT, ALU_LT);
                    {F7_BASE, F3_SLTU}: ctl = int_ctl(OP_SLTU, ALU_LTU);
                    {F7_BASE, F3_XOR}:  ctl = int_ctl(OP_XOR, ALU_XOR);
                    {F7_BASE, F3_SRL}:  ctl = int_ctl(OP_SRL, ALU_SRU);
                    {F7_ALT, F3_SRL}:   ctl = int_ctl(OP_SRA, ALU_SR);
                    {F7_BASE, F3_OR}:   ctl = int_ctl(OP_OR, ALU_OR);
                    {F7_BASE, F3_AND}:  ctl = int_ctl(OP_AND, ALU_AND);
                    default:            ctl = '0;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD:  ctl = int_ctl(OP_ADDI, ALU_ADD);
                    F3_SLT:  ctl = int_ctl(OP_SLTI, ALU_LT);
                    F3_SLTU: ctl = int_ctl(OP_SLTIU, ALU_LTU);
                    F3_XOR:  ctl = int_ctl(OP_XORI, ALU_XOR);
                    F3_OR:   ctl = int_ctl(OP_ORI, ALU_OR);
                    F3_AND:  ctl = int_ctl(OP_ANDI, ALU_AND);
                    F3_SLL: begin
                        if (funct6 == F6_BASE) begin
                            ctl = int_ctl(OP_SLLI, ALU_SL);
                        end
                    end
                    F3_SRL: begin
                        if (funct6 == F6_BASE) begin
                            ctl = int_ctl(OP_SRLI, ALU_SRU);
                        end else if (funct6 == F6_ALT) begin
                            ctl = int_ctl(OP_SRAI, ALU_SR);
                        end
                    end
                    default: ctl = '0;
                endcase
            end
            OPC_OP_32: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: ctl = int_ctl(OP_ADDW, ALU_ADD);
                    {F7_ALT, F3_ADD}:  ctl = int_ctl(OP_SUBW, ALU_SUB);
                    {F7_BASE, F3_SLL}: ctl = int_ctl(OP_SLLW, ALU_SL);
                    {F7_BASE, F3_SRL}: ctl = int_ctl(OP_SRLW, ALU_SRUW);
                    {F7_ALT, F3_SRL}:  ctl = int_ctl(OP_SRAW, ALU_SRW);
                    default:           ctl = '0;
                endcase
            end
            OPC_OP_IMM_32: begin
                // Word shift amount is 5 bits, so all of funct7 is checked
                case ({funct7, funct3})
                    {F7_BASE, F3_SLL}: ctl = int_ctl(OP_SLLIW, ALU_SL);
                    {F7_BASE, F3_SRL}: ctl = int_ctl(OP_SRLIW, ALU_SRUW);
                    {F7_ALT, F3_SRL}:  ctl = int_ctl(OP_SRAIW, ALU_SRW);
                    default: begin
                        if (funct3 == F3_ADD) begin
                            ctl = int_ctl(OP_ADDIW, ALU_ADD);   // Immediate in funct7 bits
                        end
                    end
                endcase
            end
            default: ctl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/flow_mem_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_mem_decode (
    input  logic [6:0]           opcode,
    input  logic [2:0]           funct3,
    output decode_pkg::control_t ctl,
    output logic                 hit
);
    import decode_pkg::*;

    assign hit = opcode inside {OPC_LOAD, OPC_STORE, OPC_LUI, OPC_AUIPC,
                                OPC_JAL, OPC_JALR, OPC_BRANCH};

    // Field order is op, regwrite, alufunc, mem_read, mem_write
    always_comb begin
        ctl = '0;
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   ctl = '{OP_LB, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    F3_LH:   ctl = '{OP_LH, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    F3_LW:   ctl = '{OP_LW, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    F3_LD:   ctl = '{OP_LD, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    F3_LBU:  ctl = '{OP_LBU, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    F3_LHU:  ctl = '{OP_LHU, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    F3_LWU:  ctl = '{OP_LWU, 1'b1, ALU_NOP, 1'b1, 1'b0};
                    default: ctl = '0;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   ctl = '{OP_SB, 1'b0, ALU_DIRECT, 1'b0, 1'b1};
                    F3_SH:   ctl = '{OP_SH, 1'b0, ALU_DIRECT, 1'b0, 1'b1};
                    F3_SW:   ctl = '{OP_SW, 1'b0, ALU_DIRECT, 1'b0, 1'b1};
                    F3_SD:   ctl = '{OP_SD, 1'b0, ALU_DIRECT, 1'b0, 1'b1};
                    default: ctl = '0;
                endcase
            end
            OPC_LUI:   ctl = '{OP_LUI, 1'b1, ALU_DIRECT, 1'b0, 1'b0};
            OPC_AUIPC: ctl = '{OP_AUIPC, 1'b1, ALU_ADD, 1'b0, 1'b0};
            OPC_JAL:   ctl = '{OP_JAL, 1'b1, ALU_ADD, 1'b0, 1'b0};   // Link address
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    ctl = '{OP_JALR, 1'b1, ALU_ADD, 1'b0, 1'b0};
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  ctl = '{OP_BEQ, 1'b0, ALU_NOP, 1'b0, 1'b0};
                    F3_BNE:  ctl = '{OP_BNE, 1'b0, ALU_NOP, 1'b0, 1'b0};
                    F3_BLT:  ctl = '{OP_BLT, 1'b0, ALU_NOP, 1'b0, 1'b0};
                    F3_BGE:  ctl = '{OP_BGE, 1'b0, ALU_NOP, 1'b0, 1'b0};
                    F3_BLTU: ctl = '{OP_BLTU, 1'b0, ALU_NOP, 1'b0, 1'b0};
                    F3_BGEU: ctl = '{OP_BGEU, 1'b0, ALU_NOP, 1'b0, 1'b0};
                    default: ctl = '0;   // 010 and 011 unused
                endcase
            end
            default: ctl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  decode_pkg::instr_t   instr,
    output decode_pkg::control_t ctl
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    control_t   alu_ctl;
    control_t   fm_ctl;
    logic       alu_hit;
    logic       fm_hit;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];   // Overlaps funct7

    alu_decode i_alu_decode (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .funct6 (funct6),
        .ctl    (alu_ctl),
        .hit    (alu_hit)
    );

    flow_mem_decode i_flow_mem_decode (
        .opcode (opcode),
        .funct3 (funct3),
        .ctl    (fm_ctl),
        .hit    (fm_hit)
    );

    // SYSTEM and unknown opcodes hit neither sub-decoder
    assign ctl = alu_hit ? alu_ctl : (fm_hit ? fm_ctl : '0);

endmodule

`default_nettype wire

/* src/riscv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  decode_pkg::instr_t   instr,
    output logic                 ctl_valid,
    input  logic                 ctl_ready,
    output decode_pkg::control_t ctl
);
    import decode_pkg::*;

    logic     mid_valid;
    logic     mid_ready;
    instr_t   mid_instr;
    control_t dec_ctl;

    pipe_stage #(.T(instr_t)) i_instr_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .in_data   (instr),
        .out_valid (mid_valid),
        .out_ready (mid_ready),
        .out_data  (mid_instr)
    );

    instr_decoder i_instr_decoder (
        .instr (mid_instr),
        .ctl   (dec_ctl)
    );

    // Decoder sits between the stages in the data path only
    pipe_stage #(.T(control_t)) i_ctl_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mid_valid),
        .in_ready  (mid_ready),
        .in_data   (dec_ctl),
        .out_valid (ctl_valid),
        .out_ready (ctl_ready),
        .out_data  (ctl)
    );

endmodule

`default_nettype wire

/* include/decode_ref.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Classes 0-10 walk the kept opcodes, 11-12 SYSTEM, 13-15 any opcode
function automatic instr_t build_instr(input logic [3:0] cls, input logic [1:0] f7_sel,
                                       input logic [31:0] body);
    logic [6:0] opc_list [11] = '{OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32, OPC_LOAD,
                                  OPC_STORE, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH};
    instr_t     ins;
    ins = body;
    if (cls < 4'd11) begin
        ins[6:0] = opc_list[cls];
    end else if (cls < 4'd13) begin
        ins[6:0] = 7'b1110011;
    end
    if (f7_sel == 2'd0) begin
        ins[31:26] = 6'b000000;
    end else if (f7_sel == 2'd1) begin
        ins[31:26] = 6'b010000;   // Alternate funct7 or funct6
    end
    return ins;
endfunction

function automatic control_t expect_ctl(input instr_t ins);
    op_t        reg_ops [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
    op_t        imm_ops [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI,
                                OP_ANDI};
    alu_func_t  int_fns [8] = '{ALU_ADD, ALU_SL, ALU_LT, ALU_LTU, ALU_XOR, ALU_SRU, ALU_OR,
                                ALU_AND};
    op_t        ld_ops [8] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU, OP_ILLEGAL};
    op_t        st_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
    op_t        br_ops [8] = '{OP_BEQ, OP_BNE, OP_ILLEGAL, OP_ILLEGAL, OP_BLT, OP_BGE, OP_BLTU,
                               OP_BGEU};
    logic [6:0] opc;
    logic [2:0] f3;
    logic       base;
    logic       alt;
    logic       imm;
    control_t   c;
    opc  = ins[6:0];
    f3   = ins[14:12];
    base = ins[31:25] == F7_BASE;
    alt  = ins[31:25] == F7_ALT;
    imm  = opc == OPC_OP_IMM_32;
    c    = '0;
    case (opc)
        OPC_OP: begin
            if (base || (alt && (f3 == F3_ADD || f3 == F3_SRL))) begin
                c.op      = alt ? (f3 == F3_ADD ? OP_SUB : OP_SRA) : reg_ops[f3];
                c.alufunc = alt ? (f3 == F3_ADD ? ALU_SUB : ALU_SR) : int_fns[f3];
            end
        end
        OPC_OP_IMM: begin
            if (f3 == F3_SRL && ins[31:26] == F6_ALT) begin
                c.op      = OP_SRAI;
                c.alufunc = ALU_SR;
            end else if (!(f3 == F3_SLL || f3 == F3_SRL) || ins[31:26] == F6_BASE) begin
                c.op      = imm_ops[f3];
                c.alufunc = int_fns[f3];
            end
        end
        OPC_OP_32, OPC_OP_IMM_32: begin
            if (f3 == F3_ADD && (imm || base || alt)) begin
                c.op      = imm ? OP_ADDIW : (alt ? OP_SUBW : OP_ADDW);
                c.alufunc = (alt && !imm) ? ALU_SUB : ALU_ADD;
            end else if (f3 == F3_SLL && base) begin
                c.op      = imm ? OP_SLLIW : OP_SLLW;
                c.alufunc = ALU_SL;
            end else if (f3 == F3_SRL && (base || alt)) begin
                c.op      = alt ? (imm ? OP_SRAIW : OP_SRAW) : (imm ? OP_SRLIW : OP_SRLW);
                c.alufunc = alt ? ALU_SRW : ALU_SRUW;
            end
        end
        OPC_LOAD: begin
            c.op       = ld_ops[f3];
            c.mem_read = f3 != 3'd7;
        end
        OPC_STORE: begin
            if (f3 < 3'd4) begin
                c.op        = st_ops[f3[1:0]];
                c.alufunc   = ALU_DIRECT;
                c.mem_write = 1'b1;
            end
        end
        OPC_LUI: c = '{OP_LUI, 1'b0, ALU_DIRECT, 1'b0, 1'b0};
        OPC_AUIPC: c.op = OP_AUIPC;
        OPC_JAL: c.op = OP_JAL;
        OPC_JALR: c.op = (f3 == 3'd0) ? OP_JALR : OP_ILLEGAL;
        OPC_BRANCH: c.op = br_ops[f3];
        default: c = '0;
    endcase
    if (opc inside {OPC_AUIPC, OPC_JAL, OPC_JALR} && c.op != OP_ILLEGAL) begin
        c.alufunc = ALU_ADD;   // Link or PC-relative sum
    end
    if (!(opc inside {OPC_STORE, OPC_BRANCH})) begin
        c.regwrite = c.op != OP_ILLEGAL;
    end
    return c;
endfunction

`endif

/* bench/tb_riscv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_decode;
    import decode_pkg::*;
    `include "decode_ref.svh"

    localparam int  N_INSTR = 2000;
    localparam time LIMIT   = (N_INSTR * 4 + 100) * 20;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic        instr_ready;
    instr_t      instr;
    logic        ctl_valid;
    logic        ctl_ready;
    control_t    ctl;
    logic [15:0] lfsr;
    logic [5:0]  rnd;
    control_t    exp_q [$];
    control_t    exp_head;
    logic        took;
    logic        sb_underflow;
    logic        burst;
    int          accepted;

    riscv_decode i_riscv_decode (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Inputs settled after the falling edge decide the next rising edge
    task automatic track_transfers();
        #1;
        took = instr_valid && instr_ready;
        if (ctl_valid && ctl_ready) begin
            if (exp_q.size() == 0) begin
                sb_underflow = 1'b1;
            end else begin
                exp_head = exp_q.pop_front();
            end
        end
        if (took) begin
            exp_q.push_back(expect_ctl(instr));
            accepted++;
        end
    endtask

    a_reset_idle: assert property (@(posedge clk)
        !rst_n || $rose(rst_n) |-> !ctl_valid && instr_ready)
        else abort_run($sformatf("MISMATCH {ctl_valid,instr_ready} got %h expected %h",
                                 {$sampled(ctl_valid), $sampled(instr_ready)}, 2'h1));
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        ctl_valid && ctl_ready |-> ctl == exp_head)
        else abort_run($sformatf("MISMATCH ctl got %h expected %h", $sampled(ctl),
                                 $sampled(exp_head)));
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ctl_valid && !ctl_ready |=> ctl_valid && $stable(ctl))
        else abort_run("Output changed while held back by ctl_ready");
    a_order: assert property (@(posedge clk) !sb_underflow)
        else abort_run("Output transfer with no instruction outstanding");
    a_flow: assert property (@(posedge clk) disable iff (!rst_n) ctl_ready |-> instr_ready)
        else abort_run($sformatf("MISMATCH instr_ready got %h expected %h", 1'b0, 1'b1));
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && instr_ready |-> ##2 ctl_valid)
        else abort_run("No ctl_valid one cycle after an accepted instruction");

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #LIMIT;
        abort_run("Watchdog timeout before all instructions drained");
    end

    initial begin
        lfsr         = 16'd38965;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        ctl_ready    = 1'b0;
        took         = 1'b0;
        sb_underflow = 1'b0;
        exp_head     = '0;
        accepted     = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (accepted < N_INSTR) begin
            @(negedge clk);
            burst = (accepted % 250) < 50;   // Full-flow stretch
            if (!instr_valid || took) begin
                instr_valid = burst || (next_bits(2) != 0);
                rnd         = next_bits(6);
                instr       = build_instr(rnd[5:2], rnd[1:0], next_bits(32));
            end
            ctl_ready = burst || next_bits(1);
            track_transfers();
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
            instr_valid = 1'b0;
            ctl_ready   = 1'b1;
            track_transfers();
        end
        repeat (3) begin
            @(negedge clk);
            track_transfers();   // Any further output is unmatched
        end
        @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* riscv_decode.f */
+incdir+include
src/decode_pkg.sv
src/pipe_stage.sv
src/alu_decode.sv
src/flow_mem_decode.sv
src/instr_decoder.sv
src/riscv_decode.sv
bench/tb_riscv_decode.sv
